/* hw/huff_pkg.sv */
`default_nettype none

package huff_pkg;

    // codebook geometry
    localparam int CB_DEPTH   = 256;
    localparam int CB_ADDR_W  = 8;
    localparam int PATH_W     = 128;
    localparam int PATH_BYTES = 16;          // stream bytes per symbol
    localparam int CHAR_W     = 8;
    localparam int CNT_W      = 32;          // symbol counter width

    // flow control
    localparam int IN_CREDITS  = 4;          // input fifo depth, upstream credits at reset
    localparam int OUT_CREDITS = 2;

    // derived widths and sized limits
    localparam int IN_PTR_W   = 2;
    localparam int IN_CNT_W   = 3;           // occupancy needs one more bit than the pointers
    localparam int OUT_CRED_W = 2;
    localparam int BYTE_CNT_W = 4;

    localparam logic [IN_CNT_W-1:0]   IN_FULL      = IN_CNT_W'(IN_CREDITS);
    localparam logic [OUT_CRED_W-1:0] OUT_CRED_MAX = OUT_CRED_W'(OUT_CREDITS);
    localparam logic [BYTE_CNT_W-1:0] LAST_BYTE    = BYTE_CNT_W'(PATH_BYTES - 1);
    localparam logic [CB_ADDR_W-1:0]  LAST_ADDR    = CB_ADDR_W'(CB_DEPTH - 1);

    typedef enum logic [2:0] {
        IDLE,        // wait for start
        GATHER,      // shift stream bytes into the path
        SCAN_REQ,    // issue codebook read
        SCAN_CMP,    // compare read data with the path
        EMIT,        // hand the character to the output stage
        FINISH
    } decode_state_t;

endpackage

`default_nettype wire

/* hw/codebook_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module codebook_ram (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           cb_we,
    input  wire logic [huff_pkg::CB_ADDR_W-1:0] cb_waddr,
    input  wire logic [huff_pkg::PATH_W-1:0]    cb_wdata,
    input  wire logic                           cb_rd_en,
    input  wire logic [huff_pkg::CB_ADDR_W-1:0] cb_rd_addr,
    output logic      [huff_pkg::PATH_W-1:0]    cb_rd_data
);

    // one path per character, indexed by the character itself
    logic [huff_pkg::PATH_W-1:0] mem [huff_pkg::CB_DEPTH];

    // host load port
    always_ff @(posedge clk) begin
        if (cb_we) begin
            mem[cb_waddr] <= cb_wdata;
        end
    end

    // registered read, data valid the cycle after cb_rd_en
    always_ff @(posedge clk) begin
        if (cb_rd_en) begin
            cb_rd_data <= mem[cb_rd_addr];
        end
    end

    // loading finishes before decoding, so the two ports never collide on one entry
    a_no_rw_collision: assert property (
        @(posedge clk) disable iff (rst)
        !(cb_we && cb_rd_en && (cb_waddr == cb_rd_addr))
    );

endmodule

`default_nettype wire

/* hw/byte_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module byte_fifo (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        in_valid,
    input  wire logic [huff_pkg::CHAR_W-1:0] in_byte,
    output logic                             in_credit,
    input  wire logic                        byte_pop,
    output logic      [huff_pkg::CHAR_W-1:0] fifo_byte,
    output logic                             fifo_empty
);

    logic [huff_pkg::CHAR_W-1:0]   mem [huff_pkg::IN_CREDITS];
    logic [huff_pkg::IN_PTR_W-1:0] wr_ptr;
    logic [huff_pkg::IN_PTR_W-1:0] rd_ptr;
    logic [huff_pkg::IN_CNT_W-1:0] count;
    logic                          fifo_full;

    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == huff_pkg::IN_FULL);
    assign fifo_byte  = mem[rd_ptr];   // head is visible without a pop

    // storage
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_byte;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (byte_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({in_valid, byte_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push+pop
            endcase
        end
    end

    // every freed slot goes back upstream as one credit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= byte_pop;
        end
    end

    // upstream credits bound the pushes
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst) in_valid |-> !fifo_full
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst) byte_pop |-> !fifo_empty
    );

endmodule

`default_nettype wire

/* hw/translation_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module translation_decode (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           start,
    input  wire logic [huff_pkg::CNT_W-1:0]     sym_count,
    input  wire logic [huff_pkg::CHAR_W-1:0]    fifo_byte,
    input  wire logic                           fifo_empty,
    output logic                                byte_pop,
    output logic                                cb_rd_en,
    output logic      [huff_pkg::CB_ADDR_W-1:0] cb_rd_addr,
    input  wire logic [huff_pkg::PATH_W-1:0]    cb_rd_data,
    output logic                                emit,
    output logic      [huff_pkg::CHAR_W-1:0]    emit_char,
    input  wire logic                           emit_ready,
    output logic                                no_match,
    output logic                                done
);

    huff_pkg::decode_state_t state;
    huff_pkg::decode_state_t state_nxt;

    logic [huff_pkg::PATH_W-1:0]     path;            // assembled stream path
    logic [huff_pkg::BYTE_CNT_W-1:0] byte_cnt;
    logic [huff_pkg::BYTE_CNT_W-1:0] byte_cnt_nxt;
    logic [huff_pkg::CB_ADDR_W-1:0]  scan_addr;
    logic [huff_pkg::CB_ADDR_W-1:0]  scan_addr_nxt;
    logic [huff_pkg::CNT_W-1:0]      sym_target;      // latched sym_count
    logic [huff_pkg::CNT_W-1:0]      sym_target_nxt;
    logic [huff_pkg::CNT_W-1:0]      sym_done;
    logic [huff_pkg::CNT_W-1:0]      sym_done_nxt;
    logic                            no_match_nxt;
    logic                            path_hit;
    logic                            sym_end;         // current symbol is finished

    // handshakes come straight from the state
    assign byte_pop   = (state == huff_pkg::GATHER) && !fifo_empty;
    assign cb_rd_en   = (state == huff_pkg::SCAN_REQ);
    assign cb_rd_addr = scan_addr;
    assign emit       = (state == huff_pkg::EMIT) && emit_ready;
    assign emit_char  = scan_addr;   // the matching address is the character
    assign done       = (state == huff_pkg::FINISH);

    assign path_hit = (cb_rd_data == path);

    always_comb begin
        state_nxt      = state;
        byte_cnt_nxt   = byte_cnt;
        scan_addr_nxt  = scan_addr;
        sym_target_nxt = sym_target;
        sym_done_nxt   = sym_done;
        no_match_nxt   = no_match;
        sym_end        = 1'b0;

        case (state)
            huff_pkg::IDLE: begin
                if (start) begin
                    sym_target_nxt = sym_count;
                    sym_done_nxt   = '0;
                    byte_cnt_nxt   = '0;
                    if (sym_count == '0) begin
                        state_nxt = huff_pkg::FINISH;   // nothing to decode
                    end else begin
                        state_nxt = huff_pkg::GATHER;
                    end
                end
            end

            huff_pkg::GATHER: begin
                if (!fifo_empty) begin
                    if (byte_cnt == huff_pkg::LAST_BYTE) begin
                        byte_cnt_nxt  = '0;
                        scan_addr_nxt = '0;   // scan always starts at entry 0
                        state_nxt     = huff_pkg::SCAN_REQ;
                    end else begin
                        byte_cnt_nxt = byte_cnt + 1'b1;
                    end
                end
            end

            huff_pkg::SCAN_REQ: begin
                state_nxt = huff_pkg::SCAN_CMP;
            end

            huff_pkg::SCAN_CMP: begin
                if (path_hit) begin
                    state_nxt = huff_pkg::EMIT;   // first hit wins
                end else if (scan_addr == huff_pkg::LAST_ADDR) begin
                    // whole book missed, drop the symbol
                    no_match_nxt = 1'b1;
                    sym_end      = 1'b1;
                end else begin
                    scan_addr_nxt = scan_addr + 1'b1;
                    state_nxt     = huff_pkg::SCAN_REQ;
                end
            end

            huff_pkg::EMIT: begin
                if (emit_ready) begin
                    sym_end = 1'b1;
                end
            end

            huff_pkg::FINISH: begin
                state_nxt = huff_pkg::FINISH;   // held until reset
            end

            default: begin
                state_nxt = huff_pkg::IDLE;
            end
        endcase

        // symbol bookkeeping shared by hit and miss
        if (sym_end) begin
            sym_done_nxt = sym_done + 1'b1;
            if (sym_done_nxt == sym_target) begin
                state_nxt = huff_pkg::FINISH;
            end else begin
                state_nxt = huff_pkg::GATHER;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= huff_pkg::IDLE;
            byte_cnt   <= '0;
            scan_addr  <= '0;
            sym_target <= '0;
            sym_done   <= '0;
            no_match   <= 1'b0;
        end else begin
            state      <= state_nxt;
            byte_cnt   <= byte_cnt_nxt;
            scan_addr  <= scan_addr_nxt;
            sym_target <= sym_target_nxt;
            sym_done   <= sym_done_nxt;
            no_match   <= no_match_nxt;
        end
    end

    // first popped byte ends up in the top byte after 16 shifts
    always_ff @(posedge clk) begin
        if (byte_pop) begin
            path <= {path[huff_pkg::PATH_W-huff_pkg::CHAR_W-1:0], fifo_byte};
        end
    end

    // read data and path stay put while the character waits for a credit
    a_emit_on_hit: assert property (
        @(posedge clk) disable iff (rst)
        (state == huff_pkg::EMIT) |-> path_hit
    );

endmodule

`default_nettype wire

/* hw/char_out.sv */
`timescale 1ns/100ps
`default_nettype none

module char_out (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        emit,
    input  wire logic [huff_pkg::CHAR_W-1:0] emit_char,
    output logic                             emit_ready,
    output logic                             out_valid,
    output logic      [huff_pkg::CHAR_W-1:0] out_char,
    input  wire logic                        out_credit
);

    logic [huff_pkg::OUT_CRED_W-1:0] credits;   // consumer slots still free

    assign emit_ready = (credits != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits   <= huff_pkg::OUT_CRED_MAX;
            out_valid <= 1'b0;
        end else begin
            case ({emit, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;   // spend and return cancel out
            endcase
            out_valid <= emit;   // one cycle pulse per character
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            out_char <= emit_char;
        end
    end

    // consumer returns no more than it was given
    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst) credits <= huff_pkg::OUT_CRED_MAX
    );

endmodule

`default_nettype wire

/* hw/huff_decoder_top.sv */
`timescale 1ns/100ps
`default_nettype none

module huff_decoder_top (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           cb_we,
    input  wire logic [huff_pkg::CB_ADDR_W-1:0] cb_waddr,
    input  wire logic [huff_pkg::PATH_W-1:0]    cb_wdata,
    input  wire logic                           start,
    input  wire logic [huff_pkg::CNT_W-1:0]     sym_count,
    input  wire logic                           in_valid,
    input  wire logic [huff_pkg::CHAR_W-1:0]    in_byte,
    output logic                                in_credit,
    output logic                                out_valid,
    output logic      [huff_pkg::CHAR_W-1:0]    out_char,
    input  wire logic                           out_credit,
    output logic                                no_match,
    output logic                                done
);

    logic [huff_pkg::CHAR_W-1:0]    fifo_byte;
    logic                           fifo_empty;
    logic                           byte_pop;
    logic                           cb_rd_en;
    logic [huff_pkg::CB_ADDR_W-1:0] cb_rd_addr;
    logic [huff_pkg::PATH_W-1:0]    cb_rd_data;
    logic                           emit;
    logic [huff_pkg::CHAR_W-1:0]    emit_char;
    logic                           emit_ready;

    codebook_ram codebook_ram_inst (
        .clk        (clk),
        .rst        (rst),
        .cb_we      (cb_we),
        .cb_waddr   (cb_waddr),
        .cb_wdata   (cb_wdata),
        .cb_rd_en   (cb_rd_en),
        .cb_rd_addr (cb_rd_addr),
        .cb_rd_data (cb_rd_data)
    );

    byte_fifo byte_fifo_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_byte    (in_byte),
        .in_credit  (in_credit),
        .byte_pop   (byte_pop),
        .fifo_byte  (fifo_byte),
        .fifo_empty (fifo_empty)
    );

    translation_decode translation_decode_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .sym_count  (sym_count),
        .fifo_byte  (fifo_byte),
        .fifo_empty (fifo_empty),
        .byte_pop   (byte_pop),
        .cb_rd_en   (cb_rd_en),
        .cb_rd_addr (cb_rd_addr),
        .cb_rd_data (cb_rd_data),
        .emit       (emit),
        .emit_char  (emit_char),
        .emit_ready (emit_ready),
        .no_match   (no_match),
        .done       (done)
    );

    char_out char_out_inst (
        .clk        (clk),
        .rst        (rst),
        .emit       (emit),
        .emit_char  (emit_char),
        .emit_ready (emit_ready),
        .out_valid  (out_valid),
        .out_char   (out_char),
        .out_credit (out_credit)
    );

    // the codebook is loaded before the decoder leaves IDLE
    a_no_load_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        (translation_decode_inst.state != huff_pkg::IDLE) |-> !cb_we
    );

    // a finished run stays finished and produces nothing more
    a_done_quiet: assert property (
        @(posedge clk) disable iff (rst)
        done |=> (done && !out_valid)
    );

endmodule

`default_nettype wire

/* test/tb_huff_decoder_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_huff_decoder_top;

    localparam int NUM_SYM    = 24;
    localparam int DUP_LO     = 37;    // first copy of the shared path
    localparam int DUP_HI     = 200;   // second copy, never the answer
    localparam int RST_CYCLES = 8;
    // worst case per symbol is 16 pops plus a full book scan
    localparam int TIMEOUT_CYCLES =
        NUM_SYM * (40 + 2 * huff_pkg::CB_DEPTH) + huff_pkg::CB_DEPTH + 600;

    logic                             clk;
    logic                             rst        = 1'b1;
    logic                             cb_we      = 1'b0;
    logic [huff_pkg::CB_ADDR_W-1:0]   cb_waddr   = '0;
    logic [huff_pkg::PATH_W-1:0]      cb_wdata   = '0;
    logic                             start      = 1'b0;
    logic [huff_pkg::CNT_W-1:0]       sym_count  = '0;
    logic                             in_valid   = 1'b0;
    logic [huff_pkg::CHAR_W-1:0]      in_byte    = '0;
    logic                             out_credit = 1'b0;
    logic                             in_credit;
    logic                             out_valid;
    logic [huff_pkg::CHAR_W-1:0]      out_char;
    logic                             no_match;
    logic                             done;

    // reference data
    logic [huff_pkg::PATH_W-1:0] book [huff_pkg::CB_DEPTH];
    logic [huff_pkg::CHAR_W-1:0] stream_bytes [NUM_SYM * huff_pkg::PATH_BYTES];
    logic [huff_pkg::CHAR_W-1:0] exp_char [NUM_SYM];
    int   exp_total   = 0;
    int   misses      = 0;
    int   bytes_total = 0;
    logic stream_go   = 1'b0;

    // upstream and consumer model state
    int up_credits   = huff_pkg::IN_CREDITS;
    int bytes_sent   = 0;
    int credits_back = 0;
    int out_seen     = 0;
    int owed         = 0;
    int credits_ret  = 0;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycles       = 0;

    huff_decoder_top huff_decoder_top_inst (
        .clk        (clk),
        .rst        (rst),
        .cb_we      (cb_we),
        .cb_waddr   (cb_waddr),
        .cb_wdata   (cb_wdata),
        .start      (start),
        .sym_count  (sym_count),
        .in_valid   (in_valid),
        .in_byte    (in_byte),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_char   (out_char),
        .out_credit (out_credit),
        .no_match   (no_match),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the decoder never finished", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // upstream spends one credit per byte and pauses at random
    always @(negedge clk) begin
        if (rst) begin
            in_valid     = 1'b0;
            up_credits   = huff_pkg::IN_CREDITS;
            bytes_sent   = 0;
            credits_back = 0;
        end else begin
            if (in_credit) begin
                up_credits++;
                credits_back++;
            end
            if (stream_go && up_credits > 0 && bytes_sent < bytes_total
                    && ($urandom % 4) != 0) begin
                in_valid = 1'b1;
                in_byte  = stream_bytes[bytes_sent];
                bytes_sent++;
                up_credits--;
            end else begin
                in_valid = 1'b0;
            end
        end
    end

    // consumer hands credits back after a random delay
    always @(negedge clk) begin
        if (rst) begin
            out_credit  = 1'b0;
            out_seen    = 0;
            owed        = 0;
            credits_ret = 0;
        end else begin
            if (out_valid) begin
                out_seen++;
                owed++;
            end
            if (owed > 0 && ($urandom % 3) == 0) begin
                out_credit = 1'b1;
                owed--;
                credits_ret++;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk) $fell(rst) |->
        (!out_valid && !in_credit && !no_match && !done))
    else begin
        errors++;
        $display("Error: after reset out_valid=%h in_credit=%h no_match=%h done=%h",
            $sampled(out_valid), $sampled(in_credit), $sampled(no_match), $sampled(done));
    end

    a_char_known: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_seen <= exp_total)
    else begin
        errors++;
        $display("a character came out when none was expected");
    end

    // out_seen already counts this pulse, so the entry is one back
    a_char_value: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_char == exp_char[out_seen - 1])
    else begin
        errors++;
        $display("Error: out_char=%h expected %h", $sampled(out_char), exp_char[out_seen - 1]);
    end

    a_out_credit_bound: assert property (@(posedge clk) disable iff (rst)
        out_seen <= huff_pkg::OUT_CREDITS + credits_ret)
    else begin
        errors++;
        $display("more characters came out than output credits were given");
    end

    a_in_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits_back <= bytes_sent)
    else begin
        errors++;
        $display("more input credits came back than bytes were sent");
    end

    a_no_match_sticky: assert property (@(posedge clk) disable iff (rst)
        no_match |=> no_match)
    else begin
        errors++;
        $display("no_match dropped after it was set");
    end

    a_done_sticky: assert property (@(posedge clk) disable iff (rst) done |=> done)
    else begin
        errors++;
        $display("done dropped before reset");
    end

    a_done_complete: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> (bytes_sent == bytes_total && out_seen == exp_total))
    else begin
        errors++;
        $display("done rose early: %0d of %0d bytes sent, %0d of %0d characters seen",
            bytes_sent, bytes_total, out_seen, exp_total);
    end

    a_no_match_at_done: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> no_match == (misses > 0))
    else begin
        errors++;
        $display("Error: no_match=%h expected %h", $sampled(no_match), misses > 0);
    end

    // lowest entry holding the path, -1 when the book lacks it
    function automatic int lowest_match(input logic [huff_pkg::PATH_W-1:0] p);
        for (int i = 0; i < huff_pkg::CB_DEPTH; i++) begin
            if (book[i] == p) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic [huff_pkg::PATH_W-1:0] random_path();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic build_codebook();
        logic [31:0] r;
        for (int i = 0; i < huff_pkg::CB_DEPTH; i++) begin
            r = $urandom;
            book[i] = {$urandom, $urandom, $urandom, r[31:8], 8'(i)};   // low byte keeps them apart
        end
        book[DUP_HI] = book[DUP_LO];
    endtask

    task automatic build_stream();
        logic [huff_pkg::PATH_W-1:0] p;
        int m;
        exp_total = 0;
        misses    = 0;
        for (int s = 0; s < NUM_SYM; s++) begin
            if (s % 8 == 5) begin
                do begin
                    p = random_path();
                end while (lowest_match(p) >= 0);
            end else if (s % 8 == 2) begin
                p = book[DUP_HI];
            end else begin
                p = book[$urandom % huff_pkg::CB_DEPTH];
            end
            m = lowest_match(p);
            if (m >= 0) begin
                exp_char[exp_total] = 8'(m);
                exp_total++;
            end else begin
                misses++;
            end
            for (int b = 0; b < huff_pkg::PATH_BYTES; b++) begin
                stream_bytes[s * huff_pkg::PATH_BYTES + b] = p[huff_pkg::PATH_W - 1 - 8 * b -: 8];
            end
        end
        bytes_total = NUM_SYM * huff_pkg::PATH_BYTES;
    endtask

    task automatic load_codebook();
        for (int i = 0; i < huff_pkg::CB_DEPTH; i++) begin
            @(negedge clk);
            cb_we    = 1'b1;
            cb_waddr = 8'(i);
            cb_wdata = book[i];
        end
        @(negedge clk);
        cb_we = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst       = 1'b1;
        stream_go = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_decode(input int count);
        @(negedge clk);
        sym_count = 32'(count);
        start     = 1'b1;
        @(negedge clk);
        start     = 1'b0;
        stream_go = 1'b1;
    endtask

    task automatic wait_done();
        while (!done) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d failures", tests_run, name, errors - errs_before);
        end
    endtask

    initial begin
        int mark;
        void'($urandom(20));
        build_codebook();
        build_stream();

        mark = errors;
        apply_reset();
        repeat (3) @(negedge clk);
        report_test("reset state", mark);

        mark = errors;
        load_codebook();
        run_decode(NUM_SYM);
        wait_done();
        report_test("decode stream", mark);

        mark = errors;
        repeat (20) @(negedge clk);
        report_test("done held", mark);

        // second run with nothing to decode
        mark        = errors;
        exp_total   = 0;
        misses      = 0;
        bytes_total = 0;
        apply_reset();
        run_decode(0);
        wait_done();
        repeat (20) @(negedge clk);
        report_test("zero count run", mark);

        $display("tests run %0d, tests failed %0d, check failures %0d",
            tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* huff_decoder_top.f */
hw/huff_pkg.sv
hw/codebook_ram.sv
hw/byte_fifo.sv
hw/translation_decode.sv
hw/char_out.sv
hw/huff_decoder_top.sv
test/tb_huff_decoder_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_huff_decoder_top \
        -Mdir obj_dir \
        -f huff_decoder_top.f; then
    echo "verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/Vtb_huff_decoder_top); then
    printf '%s\n' "$sim_out"
    echo "simulation exited with an error"
    exit 1
fi

printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
